// ==== source/fdc_config.svh ====
// FDC configuration constants
`ifndef FDC_CONFIG_SVH
`define FDC_CONFIG_SVH

// ====================================================================
// drive geometry and result queue
// ====================================================================
`define FDC_CYLINDERS  80 // seek target must stay below this
`define FDC_FIFO_DEPTH 4  // two bytes per command is the worst case

// main status register bit positions
`define FDC_MSR_RQM 7
`define FDC_MSR_DIO 6
`define FDC_MSR_CB  4

// status byte 0 values reported by sense interrupt
`define FDC_ST0_SEEK_END 8'h20
`define FDC_ST0_SEEK_ERR 8'hE8 // abnormal end with seek end and not ready
`define FDC_ST0_INVALID  8'h80

// status byte 3 bit positions
`define FDC_ST3_T0  4
`define FDC_ST3_RDY 5
`define FDC_ST3_WP  6
`define FDC_ST3_HD  2

`endif

// ==== source/fdc_pkg.sv ====
// FDC shared types
package fdc_pkg;

	// ================================================================
	// command decode
	// ================================================================

	// values follow the u765 opcode bytes where one exists
	typedef enum logic [7:0] {
		SPECIFY     = 8'h03,
		SENSE_DRIVE = 8'h04,
		RECALIBRATE = 8'h07,
		SENSE_INT   = 8'h08,
		SEEK        = 8'h0F,
		INVALID     = 8'hFF  // anything not listed above
	} fdc_opcode_e;

	// ================================================================
	// command engine phases
	// ================================================================

	typedef enum logic [1:0] {
		IDLE        = 2'd0, // waiting for an opcode byte
		PARAM       = 2'd1, // collecting parameter bytes
		RESULT_WAIT = 2'd2  // second result byte goes out
	} fdc_phase_e;

	// ================================================================
	// strobes between blocks
	// ================================================================

	// data register write, host port to engine
	typedef struct packed {
		logic       valid; // one cycle wide
		logic [7:0] data;
	} host_write_t;

	// result byte, engine to FIFO
	typedef struct packed {
		logic       push;  // one cycle wide, no back-pressure
		logic [7:0] data;
	} result_byte_t;

	// both strobes are single cycle pulses, the payload is
	// only meaningful while the flag bit is high

	// a command yields at most two result bytes, so the
	// result queue can not fill up between host reads

	// the opcode byte itself is carried in host_write_t.data
	// and decoded by the engine into fdc_opcode_e

endpackage

// ==== source/fdc_result_fifo.sv ====
// FDC result byte FIFO
`include "fdc_config.svh"

module fdc_result_fifo import fdc_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  result_byte_t result, // push side from the engine
	input  logic         pop,    // pop side from the host port
	output logic [7:0]   head,
	output logic         empty
);

	logic [7:0] mem [`FDC_FIFO_DEPTH];
	logic [$clog2(`FDC_FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(`FDC_FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(`FDC_FIFO_DEPTH):0]   count;
	logic do_push;
	logic do_pop;

	// advance a pointer with wrap at the last entry
	function automatic logic [$clog2(`FDC_FIFO_DEPTH)-1:0] next_ptr(
		input logic [$clog2(`FDC_FIFO_DEPTH)-1:0] ptr
	);
		if (ptr == ($clog2(`FDC_FIFO_DEPTH))'(`FDC_FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_pop  = pop & (count != '0);
	assign do_push = result.push & ((count != ($clog2(`FDC_FIFO_DEPTH) + 1)'(`FDC_FIFO_DEPTH)) | do_pop);

	// storage
	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= result.data;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign head  = mem[rd_ptr]; // oldest byte
	assign empty = (count == '0);

endmodule

// ==== source/fdc_host_port.sv ====
// FDC host bus port
`include "fdc_config.svh"

module fdc_host_port import fdc_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        a0,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic [7:0]  din,
	input  logic        busy,
	input  logic        empty,
	input  logic [7:0]  head,
	output host_write_t cmd_write,
	output logic        pop,
	output logic [7:0]  dout
);

	logic rd_level;   // read access seen this edge
	logic wr_level;
	logic rd_prev;
	logic wr_prev;
	logic rd_start;
	logic wr_start;
	logic rd_data_q;  // data register read in flight
	logic rd_stat_q;  // main status read in flight
	logic [7:0] main_status;

	// ================================================================
	// access detection
	// ================================================================

	assign rd_level = n_wr & ~n_rd;
	assign wr_level = ~n_wr & n_rd;

	assign rd_start = rd_level & ~rd_prev; // first edge of a read
	assign wr_start = wr_level & ~wr_prev;

	// ================================================================
	// main status register
	// ================================================================

	always_comb begin
		main_status = 8'h00;
		// not ready for a byte while a write is being taken
		main_status[`FDC_MSR_RQM] = ~cmd_write.valid;
		main_status[`FDC_MSR_DIO] = ~empty;        // results waiting
		main_status[`FDC_MSR_CB]  = busy | ~empty;
	end

	// ================================================================
	// strobes and read data
	// ================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_prev   <= 1'b0;
			wr_prev   <= 1'b0;
			cmd_write <= '0;
			pop       <= 1'b0;
			rd_data_q <= 1'b0;
			rd_stat_q <= 1'b0;
			dout      <= 8'h00;
		end else begin
			rd_prev <= rd_level;
			wr_prev <= wr_level;

			// command bytes are ignored while results are pending
			cmd_write.valid <= wr_start & a0 & empty;
			cmd_write.data  <= din;

			// pop decided here, so dout below sees the same choice
			pop       <= rd_start & a0 & ~empty;
			rd_data_q <= rd_start & a0;
			rd_stat_q <= rd_start & ~a0;

			// second edge of the read loads dout
			if (rd_stat_q)
				dout <= main_status;
			else if (rd_data_q)
				dout <= pop ? head : 8'hFF; // empty queue reads as ff
		end
	end

endmodule

// ==== source/fdc_command_engine.sv ====
// FDC command engine
`include "fdc_config.svh"

module fdc_command_engine import fdc_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         ready,     // drive ready
	input  host_write_t  cmd_write,
	output result_byte_t result,
	output logic         busy
);

	fdc_phase_e  phase;
	fdc_opcode_e opcode;      // command being collected
	fdc_opcode_e decoded;     // decode of the incoming byte
	logic [1:0]  params_left;
	logic [7:0]  pcn;         // present cylinder
	logic [7:0]  st0;
	logic        pending;     // interrupt pending for sense int
	logic [7:0]  second_byte; // held for the RESULT_WAIT push
	logic [7:0]  st3;
	logic [7:0]  target_cyl;
	logic        seek_ok;

	// ================================================================
	// decode
	// ================================================================

	// u765 patterns, upper bits must be zero
	function automatic fdc_opcode_e decode_opcode(input logic [7:0] code);
		case (code)
			8'h03:   return SPECIFY;
			8'h04:   return SENSE_DRIVE;
			8'h07:   return RECALIBRATE;
			8'h0F:   return SEEK;
			8'h08:   return SENSE_INT;
			default: return INVALID;
		endcase
	endfunction

	// parameter bytes that follow the opcode
	function automatic logic [1:0] param_count(input fdc_opcode_e op);
		case (op)
			SPECIFY:     return 2'd2;
			SENSE_DRIVE: return 2'd1;
			RECALIBRATE: return 2'd1;
			SEEK:        return 2'd2;
			default:     return 2'd0;
		endcase
	endfunction

	assign decoded = decode_opcode(cmd_write.data);

	// ================================================================
	// drive status
	// ================================================================

	always_comb begin
		st3 = 8'h00;
		st3[`FDC_ST3_RDY] = ready;
		st3[`FDC_ST3_WP]  = ~ready;         // no drive, report protected
		st3[`FDC_ST3_T0]  = (pcn == 8'd0);
		st3[`FDC_ST3_HD]  = cmd_write.data[2];
	end

	// seek is instant, only the range is checked
	assign target_cyl = (opcode == RECALIBRATE) ? 8'd0 : cmd_write.data;
	assign seek_ok    = (target_cyl == 8'd0) ||
		(ready && (target_cyl < `FDC_CYLINDERS));

	// busy until the last result push has left
	assign busy = (phase != IDLE) | result.push;

	// ================================================================
	// command FSM
	// ================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase       <= IDLE;
			opcode      <= INVALID;
			params_left <= 2'd0;
			pcn         <= 8'd0;
			st0         <= 8'd0;
			pending     <= 1'b0;
			result      <= '0;
		end else begin
			result.push <= 1'b0; // pulse only

			case (phase)
				IDLE: begin
					if (cmd_write.valid) begin
						opcode      <= decoded;
						params_left <= param_count(decoded);
						case (decoded)
							SENSE_INT: begin
								if (pending) begin
									result.push <= 1'b1;
									result.data <= st0;
									pending     <= 1'b0;
									phase       <= RESULT_WAIT; // cylinder follows
								end else begin
									result.push <= 1'b1;
									result.data <= `FDC_ST0_INVALID;
								end
							end
							INVALID: begin
								result.push <= 1'b1;
								result.data <= `FDC_ST0_INVALID;
								pending     <= 1'b0;
							end
							default: phase <= PARAM;
						endcase
					end
				end

				PARAM: begin
					if (cmd_write.valid) begin
						if (params_left == 2'd1) begin
							phase <= IDLE; // last parameter byte
							case (opcode)
								SEEK, RECALIBRATE: begin
									pending <= 1'b1;
									if (seek_ok) begin
										pcn <= target_cyl;
										st0 <= `FDC_ST0_SEEK_END;
									end else begin
										st0 <= `FDC_ST0_SEEK_ERR; // cylinder kept
									end
								end
								SENSE_DRIVE: begin
									result.push <= 1'b1;
									result.data <= cmd_write.data[0] ? 8'h01 : st3;
									pending     <= 1'b0;
								end
								default: ; // specify bytes are dropped
							endcase
						end else begin
							params_left <= params_left - 2'd1;
						end
					end
				end

				RESULT_WAIT: begin
					result.push <= 1'b1;
					result.data <= second_byte;
					phase       <= IDLE;
				end

				default: phase <= IDLE;
			endcase
		end
	end

	// result payload, loaded with the first sense int byte
	always_ff @(posedge clk_sys) begin
		if (phase == IDLE && cmd_write.valid)
			second_byte <= pcn;
	end

endmodule

// ==== source/fdc_top.sv ====
// FDC host side top level
`include "fdc_config.svh"

module fdc_top import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ready,  // drive ready
	input  logic       a0,     // 0 main status, 1 data register
	input  logic       n_rd,
	input  logic       n_wr,
	input  logic [7:0] din,
	output logic [7:0] dout
);

	host_write_t  cmd_write; // host to engine
	result_byte_t result;    // engine to FIFO
	logic         pop;
	logic [7:0]   head;
	logic         empty;
	logic         busy;

	// ================================================================
	// bus side, consumer of results
	// ================================================================
	fdc_host_port u_host_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.a0        (a0),
		.n_rd      (n_rd),
		.n_wr      (n_wr),
		.din       (din),
		.busy      (busy),
		.empty     (empty),
		.head      (head),
		.cmd_write (cmd_write),
		.pop       (pop),
		.dout      (dout)
	);

	// producer of result bytes
	fdc_command_engine u_command_engine (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ready     (ready),
		.cmd_write (cmd_write),
		.result    (result),
		.busy      (busy)
	);

	fdc_result_fifo u_result_fifo (
		.clk_sys (clk_sys),
		.reset   (reset),
		.result  (result),
		.pop     (pop),
		.head    (head),
		.empty   (empty)
	);

endmodule

// ==== test/tb_clock_gen.sv ====
// testbench clock and reset
module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// high for two rising edges, dropped on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

// ==== test/tb_fdc.sv ====
// FDC host side testbench
`include "fdc_config.svh"

module tb_fdc;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [7:0] pcn;
		logic [7:0] st0;
		logic       pending;
	} model_state_t;

	logic         clk_sys;
	logic         reset;
	logic         ready;
	logic         a0;
	logic         n_rd;
	logic         n_wr;
	logic [7:0]   din;
	logic [7:0]   dout;
	model_state_t model;     // expected controller state
	string        test_name;
	int           test_errors;
	int           error_count;
	int           tests_run;
	int           tests_failed;
	int           k;
	logic         released;
	logic [7:0]   status;
	logic [7:0]   value;
	logic [7:0]   cyl;
	logic [7:0]   op;

	tb_clock_gen clock_gen (.clk_sys(clk_sys), .reset(reset));

	fdc_top DUT (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ready   (ready),
		.a0      (a0),
		.n_rd    (n_rd),
		.n_wr    (n_wr),
		.din     (din),
		.dout    (dout)
	);

	// ================================================================
	// reference model
	// ================================================================

	// opcode plus parameter bytes
	function automatic int command_length(input logic [7:0] code);
		case (code)
			8'h03, 8'h0F: return 3;
			8'h04, 8'h07: return 2;
			default:      return 1;
		endcase
	endfunction

	function automatic int expected_results(
		input  logic [2:0][7:0] cmd,
		input  logic            rdy,
		input  model_state_t    st_in,
		output model_state_t    st_out,
		output logic [7:0]      first,
		output logic [7:0]      second
	);
		logic [7:0] target;
		int         count;
		st_out = st_in;
		first  = 8'h00;
		second = 8'h00;
		count  = 0;
		target = (cmd[0] == 8'h07) ? 8'h00 : cmd[2]; // recalibrate seeks to 0
		case (cmd[0])
			8'h03: count = 0;
			8'h07, 8'h0F: begin
				st_out.pending = 1'b1;
				if ((rdy && target < `FDC_CYLINDERS) || target == 8'h00) begin
					st_out.pcn = target;
					st_out.st0 = `FDC_ST0_SEEK_END;
				end else begin
					st_out.st0 = `FDC_ST0_SEEK_ERR;
				end
			end
			8'h04: begin
				count          = 1;
				st_out.pending = 1'b0;
				if (cmd[1][0]) begin
					first = 8'h01;
				end else begin
					first[`FDC_ST3_RDY] = rdy;
					first[`FDC_ST3_WP]  = ~rdy;
					first[`FDC_ST3_T0]  = (st_in.pcn == 8'h00);
					first[`FDC_ST3_HD]  = cmd[1][2];
				end
			end
			8'h08: begin
				if (st_in.pending) begin
					count          = 2;
					first          = st_in.st0;
					second         = st_in.pcn;
					st_out.pending = 1'b0;
				end else begin
					count = 1;
					first = `FDC_ST0_INVALID;
				end
			end
			default: begin
				count          = 1;
				first          = `FDC_ST0_INVALID;
				st_out.pending = 1'b0;
			end
		endcase
		return count;
	endfunction

	// ================================================================
	// bookkeeping and bus access
	// ================================================================

	task automatic check_value(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual) begin
			$display("** Error %s (%s) expected %02h actual %02h", test_name, what,
				expected, actual);
			test_errors++;
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s: %s", test_name, what);
		test_errors++;
		error_count++;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		tests_run++;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %-16s ok", test_name);
		end else begin
			$display("test %-16s %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// called on a falling edge, returns on one
	task automatic bus_write(input logic addr, input logic [7:0] data);
		a0   = addr;
		din  = data;
		n_wr = 1'b0;
		repeat (3) @(negedge clk_sys);
		n_wr = 1'b1;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic bus_read(input logic addr, output logic [7:0] data);
		a0   = addr;
		n_rd = 1'b0;
		repeat (3) @(negedge clk_sys);
		data = dout; // loaded on the second edge
		n_rd = 1'b1;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic wait_reset_release(output logic done);
		int cycles;
		done = 1'b0;
		for (cycles = 0; cycles < 20 && !done; cycles++) begin
			@(posedge clk_sys);
			done = ~reset; // reset only moves on falling edges
		end
		@(negedge clk_sys);
	endtask

	// send one command, drain results while DIO is set, compare
	task automatic run_command(input logic [2:0][7:0] cmd);
		model_state_t next_state;
		logic [7:0]   exp_first;
		logic [7:0]   exp_second;
		logic [7:0]   got_first;
		logic [7:0]   got_second;
		logic [7:0]   msr;
		logic [7:0]   data;
		logic         drained;
		int           exp_count;
		int           got_count;
		int           i;
		int           polls;
		exp_count = expected_results(cmd, ready, model, next_state, exp_first, exp_second);
		model     = next_state;
		for (i = 0; i < command_length(cmd[0]); i++)
			bus_write(1'b1, cmd[i]);
		got_count  = 0;
		got_first  = 8'h00;
		got_second = 8'h00;
		drained    = 1'b0;
		for (polls = 0; polls < 50 && !drained; polls++) begin
			bus_read(1'b0, msr);
			if (msr[`FDC_MSR_DIO]) begin
				bus_read(1'b1, data);
				if (got_count == 0)
					got_first = data;
				else if (got_count == 1)
					got_second = data;
				got_count++;
			end else begin
				drained = 1'b1;
			end
		end
		if (!drained)
			report_failure("result phase did not end");
		check_value("result count", 8'(exp_count), 8'(got_count));
		if (exp_count > 0)
			check_value("result byte 1", exp_first, got_first);
		if (exp_count > 1)
			check_value("result byte 2", exp_second, got_second);
	endtask

	// ================================================================
	// test sequence
	// ================================================================

	initial begin
		ready        = 1'b1;
		a0           = 1'b0;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		din          = 8'h00;
		model        = '0;
		test_name    = "reset";
		test_errors  = 0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(10));
		wait_reset_release(released);
		if (!released) begin
			report_failure("reset did not release");
		end else begin
			begin_test("reset state");
			bus_read(1'b0, status);
			check_value("main status", 8'h80, status); // only RQM
			run_command({16'h0000, 8'h08});
			end_test();

			begin_test("specify");
			run_command({8'($urandom), 8'($urandom), 8'h03});
			bus_read(1'b0, status);
			check_value("DIO and CB", 8'h00, status & 8'h50);
			end_test();

			begin_test("seek in range");
			ready = 1'b1;
			cyl   = 8'(1 + $urandom % (`FDC_CYLINDERS - 1));
			run_command({cyl, 8'h00, 8'h0F});
			run_command({16'h0000, 8'h08});
			run_command({16'h0000, 8'h08}); // nothing pending now
			end_test();

			begin_test("seek errors");
			cyl = 8'(`FDC_CYLINDERS + $urandom % (256 - `FDC_CYLINDERS));
			run_command({cyl, 8'h00, 8'h0F});
			run_command({16'h0000, 8'h08});
			ready = 1'b0;
			cyl   = 8'(1 + $urandom % (`FDC_CYLINDERS - 1));
			run_command({cyl, 8'h00, 8'h0F});
			run_command({16'h0000, 8'h08});
			end_test();

			begin_test("drive status");
			ready = 1'b1;
			run_command({16'h0000, 8'h07});
			run_command({8'h00, 8'h04, 8'h04}); // head 1
			ready = 1'b0;
			run_command({8'h00, 8'h04, 8'h04});
			run_command({8'h00, 8'h05, 8'h04}); // drive 1
			run_command({16'h0000, 8'h08});
			end_test();

			begin_test("random opcodes");
			for (k = 0; k < 20; k++) begin
				ready = 1'($urandom);
				case ($urandom % 8)
					0:       op = 8'h03;
					1:       op = 8'h04;
					2:       op = 8'h07;
					3:       op = 8'h0F;
					4:       op = 8'h08;
					default: op = 8'($urandom);
				endcase
				cyl = (op == 8'h0F) ? 8'($urandom % 100) : 8'($urandom);
				run_command({cyl, 8'($urandom), op});
				bus_read(1'b1, value);
				check_value("empty data read", 8'hFF, value);
			end
			end_test();
		end

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+source
source/fdc_pkg.sv
source/fdc_result_fifo.sv
source/fdc_host_port.sv
source/fdc_command_engine.sv
source/fdc_top.sv
test/tb_clock_gen.sv
test/tb_fdc.sv

// ==== run.sh ====
#!/bin/sh
# build the FDC testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fdc -f project.f -o sim_fdc \
	|| { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/sim_fdc)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "Regression passed" && exit 0 || exit 1
